// File: tlb_cfg_pkg.sv
// dtlb geometry and widths
// shared typedefs, init state encoding and small index helpers
package tlb_cfg_pkg;

  localparam int num_ways  = 4;
  localparam int num_sets  = 16;
  localparam int num_ports = 2;

  localparam int vpn_w  = 24;
  localparam int idx_w  = 4;
  localparam int tag_w  = vpn_w - idx_w;
  localparam int ppn_w  = 20;
  // attr bits 3..0 are global, no-execute, write-protect, user
  localparam int attr_w = 4;

  typedef logic [vpn_w-1:0]  vpn_t;
  typedef logic [idx_w-1:0]  set_idx_t;
  typedef logic [tag_w-1:0]  tag_t;
  typedef logic [ppn_w-1:0]  ppn_t;
  typedef logic [attr_w-1:0] attr_t;

  typedef logic [$clog2(num_ways)-1:0] way_idx_t;
  typedef logic [num_ways-1:0]         way_vec_t;
  typedef logic [$clog2(num_ways)-1:0] age_t;

  typedef enum logic {SWEEP, READY} init_state_e;

  // set index is the low vpn bits
  function automatic set_idx_t vpn_index(vpn_t vpn);
    return vpn[idx_w-1:0];
  endfunction

  function automatic tag_t vpn_tag(vpn_t vpn);
    return vpn[vpn_w-1:idx_w];
  endfunction

  // one-hot (or zero) way vector to way number
  function automatic way_idx_t way_encode(way_vec_t vec);
    way_idx_t idx;
    idx = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (vec[w]) begin
        idx = idx | way_idx_t'(w);
      end
    end
    return idx;
  endfunction

endpackage

// File: tlb_entry_pkg.sv
// dtlb data formats
// stored entry, lookup request and response, fill request
package tlb_entry_pkg;

  import tlb_cfg_pkg::*;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    ppn_t  ppn;
    attr_t attr;
  } tlb_entry_t;

  typedef struct packed {
    logic valid;
    vpn_t vpn;
  } lookup_req_t;

  // all fields zero on a miss
  typedef struct packed {
    logic     hit;
    way_idx_t way;
    ppn_t     ppn;
    attr_t    attr;
  } lookup_rsp_t;

  // en writes, invl with en clears a present entry
  typedef struct packed {
    logic     en;
    logic     invl;
    logic     force_en;
    way_idx_t force_way;
    vpn_t     vpn;
    ppn_t     ppn;
    attr_t    attr;
  } fill_req_t;

endpackage

// File: tlb_init_seq.sv
// dtlb init sequencer
// walks every set once after reset, then holds ready
`timescale 1ns/1ns

module tlb_init_seq (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  init_active,
  output tlb_cfg_pkg::set_idx_t init_index,
  output logic                  ready
);

  import tlb_cfg_pkg::*;

  init_state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= SWEEP;
      init_index <= '0;
    end else if (state == SWEEP) begin
      init_index <= init_index + 1'b1;
      // last set cleared at this edge
      if (init_index == set_idx_t'(num_sets - 1)) begin
        state <= READY;
      end
    end
  end

  assign init_active = (state == SWEEP);
  assign ready       = (state == READY);

endmodule

// File: tlb_way.sv
// dtlb way storage
// one entry per set, async reads for each lookup port and the fill index,
// written by the init sweep or by a selected fill
`timescale 1ns/1ns

module tlb_way (
  input  logic                                                  clk,
  input  tlb_entry_pkg::lookup_req_t [tlb_cfg_pkg::num_ports-1:0] lookup_req,
  input  logic                                                  init_active,
  input  tlb_cfg_pkg::set_idx_t                                 init_index,
  input  tlb_entry_pkg::fill_req_t                              fill,
  input  logic                                                  wen,
  output logic [tlb_cfg_pkg::num_ports-1:0]                     port_hit,
  output tlb_entry_pkg::tlb_entry_t [tlb_cfg_pkg::num_ports-1:0] port_entry,
  output logic                                                  fill_hit
);

  import tlb_cfg_pkg::*;
  import tlb_entry_pkg::*;

  tlb_entry_t mem [num_sets];
  tlb_entry_t fill_entry;
  tlb_entry_t new_entry;
  set_idx_t   fill_set;

  // lookup side
  for (genvar p = 0; p < num_ports; p++) begin : g_port
    assign port_entry[p] = mem[vpn_index(lookup_req[p].vpn)];
    assign port_hit[p]   = port_entry[p].valid &&
                           (port_entry[p].tag == vpn_tag(lookup_req[p].vpn));
  end

  // fill side tag compare
  assign fill_set   = vpn_index(fill.vpn);
  assign fill_entry = mem[fill_set];
  assign fill_hit   = fill_entry.valid && (fill_entry.tag == vpn_tag(fill.vpn));

  // an invalidate writes the same tag with valid cleared
  always_comb begin
    new_entry.valid = ~fill.invl;
    new_entry.tag   = vpn_tag(fill.vpn);
    new_entry.ppn   = fill.ppn;
    new_entry.attr  = fill.attr;
  end

  always_ff @(posedge clk) begin
    if (init_active) begin
      mem[init_index] <= '0;
    end else if (wen) begin
      mem[fill_set] <= new_entry;
    end
  end

endmodule

// File: tlb_lru.sv
// dtlb replacement state
// per-set age permutation, victim is the age 0 way, a touched way becomes
// youngest and the ways above its old age move down by one
`timescale 1ns/1ns

module tlb_lru (
  input  logic                       clk,
  input  logic                       init_active,
  input  tlb_cfg_pkg::set_idx_t      init_index,
  input  tlb_entry_pkg::fill_req_t   fill,
  input  logic                       fill_touch,
  input  tlb_cfg_pkg::way_idx_t      fill_way,
  input  tlb_entry_pkg::lookup_req_t port0_req,
  input  tlb_cfg_pkg::way_vec_t      port0_hit,
  output tlb_cfg_pkg::way_idx_t      victim
);

  import tlb_cfg_pkg::*;

  typedef age_t [num_ways-1:0] age_row_t;

  age_row_t age_mem [num_sets];
  age_row_t fill_row;
  age_row_t port0_row;
  age_row_t init_row;
  set_idx_t fill_set;
  set_idx_t port0_set;
  way_vec_t fill_sel;
  logic     port0_touch;

  function automatic age_row_t touch_row(age_row_t row, way_vec_t sel);
    age_row_t next;
    age_t     old_age;
    old_age = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (sel[w]) begin
        old_age = old_age | row[w];
      end
    end
    for (int w = 0; w < num_ways; w++) begin
      if (sel[w]) begin
        next[w] = age_t'(num_ways - 1);
      end else if (row[w] > old_age) begin
        next[w] = row[w] - 1'b1;
      end else begin
        next[w] = row[w];
      end
    end
    return next;
  endfunction

  // two read ports, one per update source
  assign fill_set  = vpn_index(fill.vpn);
  assign port0_set = vpn_index(port0_req.vpn);
  assign fill_row  = age_mem[fill_set];
  assign port0_row = age_mem[port0_set];

  assign fill_sel    = way_vec_t'(1) << fill_way;
  assign port0_touch = port0_req.valid && (|port0_hit);

  always_comb begin
    victim = '0;
    for (int w = 0; w < num_ways; w++) begin
      init_row[w] = age_t'(w);
      if (fill_row[w] == '0) begin
        victim = way_idx_t'(w);
      end
    end
  end

  // sweep wins over fills, fills win over port 0 hits
  always_ff @(posedge clk) begin
    if (init_active) begin
      age_mem[init_index] <= init_row;
    end else if (fill_touch) begin
      age_mem[fill_set] <= touch_row(fill_row, fill_sel);
    end else if (port0_touch) begin
      age_mem[port0_set] <= touch_row(port0_row, port0_hit);
    end
  end

endmodule

// File: tlb_write_ctrl.sv
// dtlb fill targeting
// present tag first, then the forced way, then the lru victim
`timescale 1ns/1ns

module tlb_write_ctrl (
  input  tlb_entry_pkg::fill_req_t fill,
  input  logic                     ready,
  input  tlb_cfg_pkg::way_vec_t    fill_hit,
  input  tlb_cfg_pkg::way_idx_t    victim,
  output tlb_cfg_pkg::way_vec_t    way_wen,
  output logic                     fill_touch,
  output tlb_cfg_pkg::way_idx_t    fill_way
);

  import tlb_cfg_pkg::*;

  logic active;
  logic any_hit;

  // fills are dropped until the sweep is done
  assign active  = fill.en && ready;
  assign any_hit = |fill_hit;

  always_comb begin
    if (any_hit) begin
      fill_way = way_encode(fill_hit);
    end else if (fill.force_en) begin
      fill_way = fill.force_way;
    end else begin
      fill_way = victim;
    end
  end

  // invalidate of an absent tag writes nothing
  assign fill_touch = active && (any_hit || !fill.invl);
  assign way_wen    = fill_touch ? (way_vec_t'(1) << fill_way) : '0;

endmodule

// File: tlb_read_merge.sv
// dtlb lookup response merge
// one-hot mux of the way entries per lookup port, gated by ready
`timescale 1ns/1ns

module tlb_read_merge (
  input  logic ready,
  input  tlb_cfg_pkg::way_vec_t [tlb_cfg_pkg::num_ports-1:0] port_hit,
  input  tlb_entry_pkg::tlb_entry_t
         [tlb_cfg_pkg::num_ways-1:0][tlb_cfg_pkg::num_ports-1:0] port_entry,
  output tlb_entry_pkg::lookup_rsp_t [tlb_cfg_pkg::num_ports-1:0] lookup_rsp,
  output tlb_cfg_pkg::way_vec_t port0_hit
);

  import tlb_cfg_pkg::*;

  way_vec_t [num_ports-1:0] gated_hit;

  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      gated_hit[p]       = ready ? port_hit[p] : '0;
      lookup_rsp[p].hit  = |gated_hit[p];
      lookup_rsp[p].way  = way_encode(gated_hit[p]);
      lookup_rsp[p].ppn  = '0;
      lookup_rsp[p].attr = '0;
      // and-or mux, stays zero on a miss
      for (int w = 0; w < num_ways; w++) begin
        if (gated_hit[p][w]) begin
          lookup_rsp[p].ppn  = lookup_rsp[p].ppn | port_entry[w][p].ppn;
          lookup_rsp[p].attr = lookup_rsp[p].attr | port_entry[w][p].attr;
        end
      end
    end
  end

  // feeds the lru touch
  assign port0_hit = gated_hit[0];

endmodule

// File: dtlb_top.sv
// data-side tlb, 4 ways by 16 sets
// two combinational lookup ports and one fill/invalidate port
`timescale 1ns/1ns

module dtlb_top (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  tlb_entry_pkg::lookup_req_t [tlb_cfg_pkg::num_ports-1:0] lookup_req,
  input  tlb_entry_pkg::fill_req_t                               fill,
  output tlb_entry_pkg::lookup_rsp_t [tlb_cfg_pkg::num_ports-1:0] lookup_rsp,
  output logic                                                   ready
);

  import tlb_cfg_pkg::*;
  import tlb_entry_pkg::*;

  logic                                    init_active;
  set_idx_t                                init_index;
  logic [num_ways-1:0][num_ports-1:0]      way_port_hit;
  way_vec_t [num_ports-1:0]                port_hit;
  tlb_entry_t [num_ways-1:0][num_ports-1:0] port_entry;
  way_vec_t                                fill_hit;
  way_vec_t                                way_wen;
  way_vec_t                                port0_hit;
  way_idx_t                                victim;
  way_idx_t                                fill_way;
  logic                                    fill_touch;

  tlb_init_seq init_seq_i (
    .clk         (clk),
    .rst         (rst),
    .init_active (init_active),
    .init_index  (init_index),
    .ready       (ready)
  );

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    tlb_way way_i (
      .clk         (clk),
      .lookup_req  (lookup_req),
      .init_active (init_active),
      .init_index  (init_index),
      .fill        (fill),
      .wen         (way_wen[w]),
      .port_hit    (way_port_hit[w]),
      .port_entry  (port_entry[w]),
      .fill_hit    (fill_hit[w])
    );
    // regroup hit bits by port
    for (genvar p = 0; p < num_ports; p++) begin : g_port
      assign port_hit[p][w] = way_port_hit[w][p];
    end
  end

  tlb_lru lru_i (
    .clk         (clk),
    .init_active (init_active),
    .init_index  (init_index),
    .fill        (fill),
    .fill_touch  (fill_touch),
    .fill_way    (fill_way),
    .port0_req   (lookup_req[0]),
    .port0_hit   (port0_hit),
    .victim      (victim)
  );

  tlb_write_ctrl write_ctrl_i (
    .fill       (fill),
    .ready      (ready),
    .fill_hit   (fill_hit),
    .victim     (victim),
    .way_wen    (way_wen),
    .fill_touch (fill_touch),
    .fill_way   (fill_way)
  );

  tlb_read_merge read_merge_i (
    .ready      (ready),
    .port_hit   (port_hit),
    .port_entry (port_entry),
    .lookup_rsp (lookup_rsp),
    .port0_hit  (port0_hit)
  );

endmodule

// File: tlb_assert.sv
// dtlb assertions
// hit gating by ready, single way hit per port, single way write
// that lands on the matching way when the tag is present
`timescale 1ns/1ns

module tlb_assert (
  input logic                                                    clk,
  input logic                                                    rst,
  input logic                                                    ready,
  input tlb_cfg_pkg::way_vec_t [tlb_cfg_pkg::num_ports-1:0]      port_hit,
  input tlb_entry_pkg::lookup_rsp_t [tlb_cfg_pkg::num_ports-1:0] lookup_rsp,
  input tlb_cfg_pkg::way_vec_t                                   fill_hit,
  input tlb_cfg_pkg::way_vec_t                                   way_wen
);

  import tlb_cfg_pkg::*;

  int fail_count = 0;

  for (genvar p = 0; p < num_ports; p++) begin : g_port
    // no hit before the sweep ends
    no_hit_unready: assert property (@(posedge clk) disable iff (rst)
      !ready |-> !lookup_rsp[p].hit)
    else begin
      fail_count++;
      $error("hit on port %0d while not ready", p);
    end

    one_way_hit: assert property (@(posedge clk) disable iff (rst)
      ready |-> $onehot0(port_hit[p]))
    else begin
      fail_count++;
      $error("several ways hit on port %0d", p);
    end
  end

  // a present tag must be rewritten in its own way
  wen_target: assert property (@(posedge clk) disable iff (rst)
    $onehot0(way_wen) && (fill_hit == '0 || (way_wen & ~fill_hit) == '0))
  else begin
    fail_count++;
    $error("fill wrote several ways or missed the way holding the tag");
  end

endmodule

bind dtlb_top tlb_assert assert_i (
  .clk        (clk),
  .rst        (rst),
  .ready      (ready),
  .port_hit   (port_hit),
  .lookup_rsp (lookup_rsp),
  .fill_hit   (fill_hit),
  .way_wen    (way_wen)
);

// File: tb_dtlb.sv
// dtlb testbench
// drives lookups and fills, checks every response against a behavioral model
`timescale 1ns/1ns

module tb_dtlb;

  import tlb_cfg_pkg::*;
  import tlb_entry_pkg::*;

  localparam int clk_period  = 8;
  localparam int test_cycles = 300;
  localparam int margin      = 100;

  logic                        clk;
  logic                        rst;
  lookup_req_t [num_ports-1:0] lookup_req;
  lookup_rsp_t [num_ports-1:0] lookup_rsp;
  fill_req_t                   fill;
  logic                        ready;

  // model of entries, ages and the init sweep
  logic  m_valid [num_ways][num_sets];
  tag_t  m_tag   [num_ways][num_sets];
  ppn_t  m_ppn   [num_ways][num_sets];
  attr_t m_attr  [num_ways][num_sets];
  age_t  m_age   [num_sets][num_ways];
  logic  m_ready;
  int    m_cnt;

  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] rnd;
  string       test_name;

  dtlb_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .lookup_req (lookup_req),
    .fill       (fill),
    .lookup_rsp (lookup_rsp),
    .ready      (ready)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected response from the model state
  function automatic lookup_rsp_t ref_lookup(lookup_req_t req);
    lookup_rsp_t rsp;
    set_idx_t    s;
    rsp = '0;
    s   = req.vpn[idx_w-1:0];
    for (int w = 0; w < num_ways; w++) begin
      if (m_ready && m_valid[w][s] && m_tag[w][s] == req.vpn[vpn_w-1:idx_w]) begin
        rsp.hit  = 1'b1;
        rsp.way  = way_idx_t'(w);
        rsp.ppn  = m_ppn[w][s];
        rsp.attr = m_attr[w][s];
      end
    end
    return rsp;
  endfunction

  task automatic age_touch(int s, int t);
    age_t old_age;
    old_age = m_age[s][t];
    for (int w = 0; w < num_ways; w++) begin
      if (w == t) begin
        m_age[s][w] = age_t'(num_ways - 1);
      end else if (m_age[s][w] > old_age) begin
        m_age[s][w] = m_age[s][w] - 1'b1;
      end
    end
  endtask

  // one rising edge of the model
  task automatic model_step();
    lookup_rsp_t rsp;
    int          s;
    int          tgt;
    tgt = -1;
    s   = fill.vpn[idx_w-1:0];
    if (rst) begin
      m_ready = 1'b0;
      m_cnt   = 0;
    end else if (!m_ready) begin
      for (int w = 0; w < num_ways; w++) begin
        m_valid[w][m_cnt] = 1'b0;
        m_age[m_cnt][w]   = age_t'(w);
      end
      m_ready = (m_cnt == num_sets - 1);
      m_cnt++;
    end else begin
      if (fill.en) begin
        for (int w = 0; w < num_ways; w++) begin
          if (m_valid[w][s] && m_tag[w][s] == fill.vpn[vpn_w-1:idx_w]) begin
            tgt = w;
          end
        end
        if (tgt < 0 && !fill.invl) begin
          for (int w = 0; w < num_ways; w++) begin
            if (m_age[s][w] == 0) begin
              tgt = w;
            end
          end
          if (fill.force_en) begin
            tgt = fill.force_way;
          end
        end
        if (tgt >= 0) begin
          m_valid[tgt][s] = !fill.invl;
          m_tag[tgt][s]   = fill.vpn[vpn_w-1:idx_w];
          m_ppn[tgt][s]   = fill.ppn;
          m_attr[tgt][s]  = fill.attr;
          age_touch(s, tgt);
        end
      end
      rsp = ref_lookup(lookup_req[0]);
      if (tgt < 0 && lookup_req[0].valid && rsp.hit) begin
        age_touch(lookup_req[0].vpn[idx_w-1:0], rsp.way);
      end
    end
  endtask

  always @(posedge clk) model_step();

  task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // responses are settled 1 ns before the next edge
  always begin
    @(posedge clk);
    #(clk_period - 1);
    check_val("ready", m_ready, ready);
    for (int p = 0; p < num_ports; p++) begin
      check_val($sformatf("port %0d response", p), ref_lookup(lookup_req[p]), lookup_rsp[p]);
    end
  end

  task automatic do_fill(vpn_t vpn, ppn_t ppn, attr_t attr, logic invl, logic force_en,
                         way_idx_t force_way);
    fill.en        = 1'b1;
    fill.invl      = invl;
    fill.force_en  = force_en;
    fill.force_way = force_way;
    fill.vpn       = vpn;
    fill.ppn       = ppn;
    fill.attr      = attr;
    @(posedge clk);
    #1;
    fill = '0;
  endtask

  task automatic probe(int p, vpn_t vpn, logic hit, way_idx_t way, ppn_t ppn, attr_t attr);
    lookup_req[p].valid = 1'b1;
    lookup_req[p].vpn   = vpn;
    #4;
    check_val($sformatf("hit %h", vpn), hit, lookup_rsp[p].hit);
    check_val($sformatf("way %h", vpn), way, lookup_rsp[p].way);
    check_val($sformatf("ppn %h", vpn), ppn, lookup_rsp[p].ppn);
    check_val($sformatf("attr %h", vpn), attr, lookup_rsp[p].attr);
    @(posedge clk);
    #1;
    lookup_req[p].valid = 1'b0;
  endtask

  // tag pool of six over sets 12 to 14
  function automatic vpn_t pick_vpn(logic [2:0] k, logic [1:0] s);
    return {20'h00C00 + 20'(k % 6), 4'(12 + s % 3)};
  endfunction

  initial begin
    #((test_cycles + margin) * clk_period);
    $display("timeout: tests did not finish within %0d cycles", test_cycles + margin);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    fill       = '0;
    lookup_req = '0;
    m_ready    = 1'b0;
    m_cnt      = 0;
    errors     = 0;
    checks     = 0;
    rnd        = 32'h124;
    test_name  = "reset";
    repeat (5) @(posedge clk);
    #1;
    check_val("ready in reset", 0, ready);

    // fill held through the whole sweep into set 0, which is swept first
    test_name = "init_sweep";
    rst       = 1'b0;
    fill.en   = 1'b1;
    fill.vpn  = 24'h000050;
    fill.ppn  = 20'h12345;
    cycles    = 0;
    while (ready !== 1'b1 && cycles < 40) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    fill = '0;
    check_val("cycles to ready", 16, cycles);
    probe(0, 24'h000050, 0, 0, 0, 0);

    test_name = "fill_lookup";
    for (int i = 0; i < 6; i++) begin
      do_fill({20'h00A00 + 20'(i), 4'(i)}, 20'h30000 + 20'(i * 17), 4'(i + 3), 0, 0, 0);
    end
    for (int i = 0; i < 6; i++) begin
      probe(0, {20'h00A00 + 20'(i), 4'(i)}, 1, 0, 20'h30000 + 20'(i * 17), 4'(i + 3));
      probe(1, {20'h00B00 + 20'(i), 4'(i)}, 0, 0, 0, 0);
    end

    // starting ages send the fills to ways 0, 1, 2, 3, then way 0 again
    test_name = "eviction_order";
    for (int i = 0; i < 5; i++) begin
      do_fill({20'h00D00 + 20'(i), 4'hA}, 20'h40000 + 20'(i), 4'(i), 0, 0, 0);
    end
    probe(1, {20'h00D00, 4'hA}, 0, 0, 0, 0);
    for (int i = 1; i < 5; i++) begin
      probe(1, {20'h00D00 + 20'(i), 4'hA}, 1, way_idx_t'(i % 4), 20'h40000 + 20'(i), 4'(i));
    end

    test_name = "random_mix";
    for (int i = 0; i < 150; i++) begin
      rnd                 = xorshift(rnd);
      fill.en             = rnd[0];
      fill.invl           = (rnd[3:1] == 0);
      fill.force_en       = (rnd[6:4] == 0);
      fill.force_way      = rnd[8:7];
      fill.vpn            = pick_vpn(rnd[11:9], rnd[13:12]);
      fill.ppn            = ppn_t'(rnd[31:14]);
      fill.attr           = rnd[17:14];
      lookup_req[0].valid = rnd[18];
      lookup_req[0].vpn   = pick_vpn(rnd[21:19], rnd[23:22]);
      lookup_req[1].valid = 1'b1;
      lookup_req[1].vpn   = pick_vpn(rnd[26:24], rnd[28:27]);
      @(posedge clk);
      #1;
    end
    fill       = '0;
    lookup_req = '0;
    // survivors are compared by the response checker
    for (int k = 0; k < 6; k++) begin
      for (int s = 0; s < 3; s++) begin
        lookup_req[1].vpn = pick_vpn(3'(k), 2'(s));
        @(posedge clk);
        #1;
      end
    end

    test_name = "refill";
    do_fill({20'h0E001, 4'hF}, 20'h5A5A5, 4'h1, 0, 0, 0);
    probe(1, {20'h0E001, 4'hF}, 1, 0, 20'h5A5A5, 4'h1);
    // present tag wins over the forced way
    do_fill({20'h0E001, 4'hF}, 20'h6B6B6, 4'h2, 0, 1, 3);
    probe(1, {20'h0E001, 4'hF}, 1, 0, 20'h6B6B6, 4'h2);
    test_name = "forced_way";
    do_fill({20'h0E002, 4'hF}, 20'h7C7C7, 4'h3, 0, 1, 2);
    probe(1, {20'h0E002, 4'hF}, 1, 2, 20'h7C7C7, 4'h3);
    test_name = "invalidate";
    do_fill({20'h0E001, 4'hF}, 0, 0, 1, 0, 0);
    probe(1, {20'h0E001, 4'hF}, 0, 0, 0, 0);
    // absent tag aimed at the way holding 0E002 must not touch it
    do_fill({20'h0E003, 4'hF}, 0, 0, 1, 1, 2);
    probe(1, {20'h0E002, 4'hF}, 1, 2, 20'h7C7C7, 4'h3);

    @(posedge clk);
    #1;
    errors = errors + dut_i.assert_i.fail_count;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: list.f
tlb_cfg_pkg.sv
tlb_entry_pkg.sv
tlb_init_seq.sv
tlb_way.sv
tlb_lru.sv
tlb_write_ctrl.sv
tlb_read_merge.sv
dtlb_top.sv
tlb_assert.sv
tb_dtlb.sv
